// File: hw/exu_pkg.sv
package exu_pkg;

	localparam int xlen = 64; // data and address width
	localparam int ilen = 32;
	localparam int reg_addr_w = 5;
	localparam int branch_imm_w = 12; // offset bits 12 down to 1
	localparam int word_w = 32; // width of the *w operations
	localparam int shamt_w = 6; // 64-bit shift amount
	localparam int shamt_word_w = 5;

	// ALU opcodes as decoded upstream; 19 and above are unused here
	typedef enum logic [4:0] {
		alu_add  = 5'd0,
		alu_addw = 5'd1,
		alu_sll  = 5'd2,
		alu_sllw = 5'd3,
		alu_sra  = 5'd4,
		alu_sraw = 5'd5,
		alu_srl  = 5'd6,
		alu_srlw = 5'd7,
		alu_and  = 5'd8,
		alu_or   = 5'd9,
		alu_xor  = 5'd10,
		alu_slt  = 5'd11,
		alu_sltu = 5'd12,
		alu_eq   = 5'd13,
		alu_ne   = 5'd14,
		alu_ge   = 5'd15,
		alu_geu  = 5'd16,
		alu_sub  = 5'd17,
		alu_subw = 5'd18
	} alu_op_e;

	typedef enum logic [6:0] {
		opcode_branch = 7'b1100011 // B-type
	} opcode_e;

	// control fields carried from decode to the memory stage
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [ilen-1:0] ins;
		logic mem_w_en;
		logic wb_sel; // 0 result, 1 memory data
		logic reg_w_en;
		logic [reg_addr_w-1:0] rdest;
		logic [xlen-1:0] rt_data; // store data
	} ex_ctrl_t;

	typedef struct packed {
		ex_ctrl_t ctrl;
		logic [xlen-1:0] alu_result;
	} ex_out_t;

	// bypass toward the operand muxes of decode
	typedef struct packed {
		logic reg_w_en;
		logic [reg_addr_w-1:0] rdest;
		logic [xlen-1:0] value;
	} fwd_t;

	function automatic logic [xlen-1:0] sext_word(input logic [word_w-1:0] w);
		return {{(xlen-word_w){w[word_w-1]}}, w};
	endfunction

	function automatic logic [xlen-1:0] zext_flag(input logic f);
		return {{(xlen-1){1'b0}}, f};
	endfunction

	function automatic logic [xlen-1:0] sext_branch(
		input logic [branch_imm_w-1:0] imm
	);
		return {{(xlen-branch_imm_w-1){imm[branch_imm_w-1]}}, imm, 1'b0};
	endfunction

endpackage

// File: hw/alu.sv
`timescale 1ns/100ps

module alu
	import exu_pkg::*;
(
	input alu_op_e op,
	input logic [xlen-1:0] src_a,
	input logic [xlen-1:0] src_b,
	output logic [xlen-1:0] result
);

	logic [shamt_w-1:0] shamt;
	logic [shamt_word_w-1:0] shamt_word;
	logic [word_w-1:0] a_word;
	logic [word_w-1:0] b_word;

	logic [xlen-1:0] sum;
	logic [xlen-1:0] diff;
	logic [word_w-1:0] sum_word;
	logic [word_w-1:0] diff_word;

	logic [word_w-1:0] sll_word;
	logic [word_w-1:0] srl_word;
	logic [word_w-1:0] sra_word;

	logic lt_s;
	logic lt_u;
	logic eq;

	assign shamt = src_b[shamt_w-1:0];
	assign shamt_word = src_b[shamt_word_w-1:0];
	assign a_word = src_a[word_w-1:0];
	assign b_word = src_b[word_w-1:0];

	// one adder and one subtractor per width
	assign sum = src_a + src_b;
	assign diff = src_a - src_b;
	assign sum_word = a_word + b_word;
	assign diff_word = a_word - b_word;

	assign sll_word = a_word << shamt_word;
	assign srl_word = a_word >> shamt_word;
	assign sra_word = $signed(a_word) >>> shamt_word;

	assign lt_s = $signed(src_a) < $signed(src_b);
	assign lt_u = src_a < src_b;
	assign eq = src_a == src_b;

	always_comb begin
		case (op)
			alu_add: begin
				result = sum;
			end
			alu_addw: begin
				result = sext_word(sum_word);
			end
			alu_sll: begin
				result = src_a << shamt;
			end
			alu_sllw: begin
				result = sext_word(sll_word);
			end
			alu_sra: begin
				result = $signed(src_a) >>> shamt;
			end
			alu_sraw: begin
				result = sext_word(sra_word);
			end
			alu_srl: begin
				result = src_a >> shamt;
			end
			alu_srlw: begin
				result = sext_word(srl_word); // bit 31 can be set when shamt is 0
			end
			alu_and: begin
				result = src_a & src_b;
			end
			alu_or: begin
				result = src_a | src_b;
			end
			alu_xor: begin
				result = src_a ^ src_b;
			end
			alu_slt: begin
				result = zext_flag(lt_s);
			end
			alu_sltu: begin
				result = zext_flag(lt_u);
			end
			alu_eq: begin
				result = zext_flag(eq);
			end
			alu_ne: begin
				result = zext_flag(!eq);
			end
			alu_ge: begin
				result = zext_flag(!lt_s);
			end
			alu_geu: begin
				result = zext_flag(!lt_u);
			end
			alu_sub: begin
				result = diff;
			end
			alu_subw: begin
				result = sext_word(diff_word);
			end
			default: begin
				result = '0; // mul/div codes are not handled here
			end
		endcase
	end

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/100ps

module branch_unit
	import exu_pkg::*;
(
	input logic valid_in,
	input logic ready_out,
	input logic [xlen-1:0] pc,
	input logic [ilen-1:0] ins,
	input logic branch,
	input logic [branch_imm_w-1:0] branch_imm,
	input logic [xlen-1:0] alu_result,
	output logic branch_taken,
	output logic bubble,
	output logic [xlen-1:0] branch_target
);

	logic is_branch;
	logic fire;

	assign is_branch = ins[6:0] == opcode_branch;
	assign fire = valid_in && ready_out;

	// offset is in halfwords
	assign branch_target = pc + sext_branch(branch_imm);

	// compare result from the ALU decides the branch
	assign branch_taken = branch && (alu_result != '0);

	// squash the younger instruction in decode
	assign bubble = is_branch && fire;

endmodule

// File: hw/ex_stage_reg.sv
`timescale 1ns/100ps

module ex_stage_reg
	import exu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic ready_out,
	input ex_out_t d,
	output logic valid_out,
	output ex_out_t q
);

	logic load;

	// advance whenever downstream can take the slot
	assign load = ready_out;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (load) begin
			valid_out <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			q.ctrl.pc <= '0;
			q.ctrl.ins <= '0;
			q.ctrl.mem_w_en <= 1'b0;
			q.ctrl.wb_sel <= 1'b0;
			q.ctrl.reg_w_en <= 1'b0;
			q.ctrl.rdest <= '0;
			q.ctrl.rt_data <= '0;
			q.alu_result <= '0;
		end else if (load) begin
			q.ctrl.pc <= d.ctrl.pc;
			q.ctrl.ins <= d.ctrl.ins;
			q.ctrl.mem_w_en <= d.ctrl.mem_w_en;
			q.ctrl.wb_sel <= d.ctrl.wb_sel;
			q.ctrl.reg_w_en <= d.ctrl.reg_w_en;
			q.ctrl.rdest <= d.ctrl.rdest;
			q.ctrl.rt_data <= d.ctrl.rt_data;
			q.alu_result <= d.alu_result;
		end
	end

endmodule

// File: hw/ex_stage.sv
`timescale 1ns/100ps

module ex_stage
	import exu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic ready_out,
	input ex_ctrl_t ctrl,
	input alu_op_e alu_op,
	input logic [xlen-1:0] src_a,
	input logic [xlen-1:0] src_b,
	input logic branch,
	input logic [branch_imm_w-1:0] branch_imm,
	output logic ready_in,
	output logic valid_out,
	output ex_out_t stage_out,
	output fwd_t fwd,
	output logic branch_taken,
	output logic bubble,
	output logic [xlen-1:0] branch_target
);

	logic [xlen-1:0] alu_result;
	ex_out_t reg_d;

	// single-cycle stage, no local stall source
	assign ready_in = ready_out;

	alu alu_i (
		.op     (alu_op),
		.src_a  (src_a),
		.src_b  (src_b),
		.result (alu_result)
	);

	branch_unit branch_unit_i (
		.valid_in      (valid_in),
		.ready_out     (ready_out),
		.pc            (ctrl.pc),
		.ins           (ctrl.ins),
		.branch        (branch),
		.branch_imm    (branch_imm),
		.alu_result    (alu_result),
		.branch_taken  (branch_taken),
		.bubble        (bubble),
		.branch_target (branch_target)
	);

	assign reg_d.ctrl = ctrl;
	assign reg_d.alu_result = alu_result;

	// bypass straight from the ALU, same cycle
	assign fwd.reg_w_en = ctrl.reg_w_en;
	assign fwd.rdest = ctrl.rdest;
	assign fwd.value = alu_result;

	ex_stage_reg ex_stage_reg_i (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.ready_out (ready_out),
		.d         (reg_d),
		.valid_out (valid_out),
		.q         (stage_out)
	);

endmodule

// File: verification/ex_stage_assertions.sv
`timescale 1ns/100ps

module ex_stage_assertions
	import exu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic ready_out,
	input ex_ctrl_t ctrl,
	input alu_op_e alu_op,
	input logic [xlen-1:0] src_a,
	input logic [xlen-1:0] src_b,
	input logic branch,
	input logic [branch_imm_w-1:0] branch_imm,
	input logic ready_in,
	input logic valid_out,
	input ex_out_t stage_out,
	input fwd_t fwd,
	input logic branch_taken,
	input logic bubble,
	input logic [xlen-1:0] branch_target
);

	int error_count = 0;

	logic [xlen-1:0] ref_result;
	ex_out_t exp_out;
	fwd_t exp_fwd;
	logic [xlen-1:0] exp_target;
	logic exp_bubble;

	logic prev_valid_in;
	ex_out_t prev_exp_out;
	logic prev_valid_out;
	ex_out_t prev_stage_out;

	function automatic logic [xlen-1:0] ref_alu(
		input logic [4:0] op,
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b
	);
		logic [31:0] w;
		logic [xlen-1:0] r;
		w = '0;
		r = '0;
		case (op)
			alu_addw: w = a[31:0] + b[31:0];
			alu_subw: w = a[31:0] - b[31:0];
			alu_sllw: w = a[31:0] << b[4:0];
			alu_srlw: w = a[31:0] >> b[4:0];
			alu_sraw: w = $signed(a[31:0]) >>> b[4:0];
			alu_add: r = a + b;
			alu_sub: r = a - b;
			alu_sll: r = a << b[5:0];
			alu_srl: r = a >> b[5:0];
			alu_sra: r = $signed(a) >>> b[5:0];
			alu_and: r = a & b;
			alu_or: r = a | b;
			alu_xor: r = a ^ b;
			alu_slt: r = {63'd0, $signed(a) < $signed(b)};
			alu_sltu: r = {63'd0, a < b};
			alu_eq: r = {63'd0, a == b};
			alu_ne: r = {63'd0, a != b};
			alu_ge: r = {63'd0, $signed(a) >= $signed(b)};
			alu_geu: r = {63'd0, a >= b};
			default: r = '0; // codes 19 to 31
		endcase
		if (op inside {alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw}) begin
			r = {{32{w[31]}}, w};
		end
		return r;
	endfunction

	assign ref_result = ref_alu(alu_op, src_a, src_b);
	assign exp_out = {ctrl, ref_result};
	assign exp_fwd = {ctrl.reg_w_en, ctrl.rdest, ref_result};
	assign exp_target = ctrl.pc + xlen'($signed(branch_imm)) * 2; // halfword offset
	assign exp_bubble = (ctrl.ins[6:0] == opcode_branch) && valid_in && ready_out;

	// one-cycle history for the register checks
	always_ff @(posedge clk) begin
		prev_valid_in <= valid_in;
		prev_exp_out <= exp_out;
		prev_valid_out <= valid_out;
		prev_stage_out <= stage_out;
	end

	reset_clear: assert property (@(posedge clk)
		$fell(reset) |-> !valid_out && stage_out == '0)
	else begin
		error_count++;
		$error("** Error valid_out/stage_out after reset: got %h/%h, expected 0/0",
			$sampled(valid_out), $sampled(stage_out));
	end

	ready_follow: assert property (@(posedge clk) ready_in == ready_out)
	else begin
		error_count++;
		$error("** Error ready_in: got %h, expected %h", $sampled(ready_in), $sampled(ready_out));
	end

	load_valid: assert property (@(posedge clk) disable iff (reset)
		ready_out |=> valid_out == prev_valid_in)
	else begin
		error_count++;
		$error("** Error valid_out: got %h, expected %h",
			$sampled(valid_out), $sampled(prev_valid_in));
	end

	load_ctrl: assert property (@(posedge clk) disable iff (reset)
		ready_out |=> stage_out.ctrl == prev_exp_out.ctrl)
	else begin
		error_count++;
		$error("** Error stage_out.ctrl: got %h, expected %h",
			$sampled(stage_out.ctrl), $sampled(prev_exp_out.ctrl));
	end

	load_result: assert property (@(posedge clk) disable iff (reset)
		ready_out |=> stage_out.alu_result == prev_exp_out.alu_result)
	else begin
		error_count++;
		$error("** Error stage_out.alu_result: got %h, expected %h",
			$sampled(stage_out.alu_result), $sampled(prev_exp_out.alu_result));
	end

	hold_stage: assert property (@(posedge clk) disable iff (reset)
		!ready_out |=> valid_out == prev_valid_out && stage_out == prev_stage_out)
	else begin
		error_count++;
		$error("** Error stage_out under back-pressure: got %h, expected %h",
			$sampled({valid_out, stage_out}), $sampled({prev_valid_out, prev_stage_out}));
	end

	fwd_value: assert property (@(posedge clk) fwd == exp_fwd)
	else begin
		error_count++;
		$error("** Error fwd: got %h, expected %h", $sampled(fwd), $sampled(exp_fwd));
	end

	target_value: assert property (@(posedge clk) branch_target == exp_target)
	else begin
		error_count++;
		$error("** Error branch_target: got %h, expected %h",
			$sampled(branch_target), $sampled(exp_target));
	end

	taken_value: assert property (@(posedge clk)
		branch_taken == (branch && ref_result != '0))
	else begin
		error_count++;
		$error("** Error branch_taken: got %h, expected %h",
			$sampled(branch_taken), $sampled(branch && ref_result != '0));
	end

	bubble_value: assert property (@(posedge clk) bubble == exp_bubble)
	else begin
		error_count++;
		$error("** Error bubble: got %h, expected %h", $sampled(bubble), $sampled(exp_bubble));
	end

endmodule

bind ex_stage ex_stage_assertions assertions_i (
	.clk           (clk),
	.reset         (reset),
	.valid_in      (valid_in),
	.ready_out     (ready_out),
	.ctrl          (ctrl),
	.alu_op        (alu_op),
	.src_a         (src_a),
	.src_b         (src_b),
	.branch        (branch),
	.branch_imm    (branch_imm),
	.ready_in      (ready_in),
	.valid_out     (valid_out),
	.stage_out     (stage_out),
	.fwd           (fwd),
	.branch_taken  (branch_taken),
	.bubble        (bubble),
	.branch_target (branch_target)
);

// File: verification/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb
	import exu_pkg::*;
();

	localparam int min_cycles = 400;
	localparam int cover_timeout = 4000;
	localparam int handshake_timeout = 20;

	logic clk;
	logic reset;
	logic valid_in;
	logic ready_out;
	ex_ctrl_t ctrl;
	alu_op_e alu_op;
	logic [xlen-1:0] src_a;
	logic [xlen-1:0] src_b;
	logic branch;
	logic [branch_imm_w-1:0] branch_imm;
	logic ready_in;
	logic valid_out;
	ex_out_t stage_out;
	fwd_t fwd;
	logic branch_taken;
	logic bubble;
	logic [xlen-1:0] branch_target;

	integer seed;
	int op_hits [32];
	int ready_hi_hits;
	int ready_lo_hits;
	int bubble_hits;
	int taken_hits;
	int not_taken_hits;
	int timeouts;
	int unreached;
	int assert_errors;

	ex_stage ex_stage_i (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [63:0] random_dword();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [63:0] edge_value(input logic [1:0] idx);
		case (idx)
			2'd0: return 64'h8000_0000_0000_0000;
			2'd1: return 64'h7fff_ffff_ffff_ffff;
			2'd2: return 64'h0000_0000_8000_0000; // word sign bit
			default: return 64'hffff_ffff_7fff_ffff;
		endcase
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		logic [31:0] ins_r;
		r = $random(seed);
		alu_op = alu_op_e'(r[4:0]); // 19 to 31 are unused codes
		case (r[6:5])
			2'd0: begin
				src_a = random_dword();
				src_b = src_a;
			end
			2'd1: begin
				src_a = edge_value(r[8:7]);
				src_b = edge_value(r[10:9]);
			end
			default: begin
				src_a = random_dword();
				src_b = random_dword();
			end
		endcase
		valid_in = r[11];
		ready_out = r[12] | r[13]; // mostly ready
		branch = r[14];
		branch_imm = r[26:15];
		ins_r = $random(seed);
		if (r[27] && r[28]) begin
			ins_r[6:0] = opcode_branch;
		end
		ctrl.pc = random_dword();
		ctrl.ins = ins_r;
		ctrl.mem_w_en = r[29];
		ctrl.wb_sel = r[30];
		ctrl.reg_w_en = r[31];
		ctrl.rdest = ins_r[11:7];
		ctrl.rt_data = random_dword();
	endtask

	task automatic step_random();
		@(posedge clk);
		#1;
		drive_random();
	endtask

	function automatic bit all_reached();
		bit ok;
		int unused_hits;
		ok = ready_hi_hits > 0 && ready_lo_hits > 0 && bubble_hits > 0;
		ok = ok && taken_hits > 0 && not_taken_hits > 0;
		unused_hits = 0;
		for (int i = 0; i < 32; i++) begin
			if (i < 19) begin
				ok = ok && op_hits[i] > 0;
			end else begin
				unused_hits += op_hits[i];
			end
		end
		return ok && unused_hits > 0;
	endfunction

	// keep stimulating until every behavior has been seen
	task automatic wait_for_coverage();
		int n;
		n = 0;
		while (!all_reached() && n < cover_timeout) begin
			step_random();
			n++;
		end
		if (!all_reached()) begin
			timeouts++;
			$display("timeout: not every behavior was reached within %0d cycles", cover_timeout);
		end
	endtask

	task automatic wait_for_valid(input logic level);
		int n;
		n = 0;
		while (valid_out !== level && n < handshake_timeout) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (valid_out !== level) begin
			timeouts++;
			$display("timeout: valid_out did not reach %0d within %0d cycles", level,
				handshake_timeout);
		end
	endtask

	task automatic report_unreached();
		for (int i = 0; i < 19; i++) begin
			if (op_hits[i] == 0) begin
				unreached++;
				$display("opcode %0d was never loaded into the stage register", i);
			end
		end
		if (ready_lo_hits == 0 || bubble_hits == 0 || taken_hits == 0) begin
			unreached++;
			$display("back-pressure, bubble or taken branch was never reached");
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			if (ready_out) begin
				ready_hi_hits++;
				op_hits[alu_op]++;
			end else begin
				ready_lo_hits++;
			end
			if (ctrl.ins[6:0] == opcode_branch && valid_in && ready_out) begin
				bubble_hits++;
			end
			if (branch && branch_taken) begin
				taken_hits++;
			end
			if (branch && !branch_taken) begin
				not_taken_hits++;
			end
		end
	end

	initial begin
		seed = 32'h43d9;
		ready_hi_hits = 0;
		ready_lo_hits = 0;
		bubble_hits = 0;
		taken_hits = 0;
		not_taken_hits = 0;
		timeouts = 0;
		unreached = 0;
		for (int i = 0; i < 32; i++) begin
			op_hits[i] = 0;
		end
		reset = 1'b1;
		drive_random(); // live data during reset, only reset can clear the register
		valid_in = 1'b1;
		ready_out = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		drive_random();
		for (int i = 0; i < min_cycles; i++) begin
			step_random();
		end
		wait_for_coverage();

		// one item in, then stall and drain
		@(posedge clk);
		#1;
		drive_random();
		valid_in = 1'b1;
		ready_out = 1'b1;
		@(posedge clk);
		#1;
		valid_in = 1'b0;
		ready_out = 1'b0;
		wait_for_valid(1'b1);
		repeat (3) @(posedge clk);
		#1;
		ready_out = 1'b1;
		wait_for_valid(1'b0);

		report_unreached();
		repeat (3) @(posedge clk);
		#1;
		assert_errors = ex_stage_i.assertions_i.error_count;
		$display("errors: %0d assertion, %0d timeout, %0d unreached", assert_errors, timeouts,
			unreached);
		if (assert_errors + timeouts + unreached == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: src.f
hw/exu_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/ex_stage_reg.sv
hw/ex_stage.sv
verification/ex_stage_assertions.sv
verification/ex_stage_tb.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - hw/exu_pkg.sv
      - hw/alu.sv
      - hw/branch_unit.sv
      - hw/ex_stage_reg.sv
      - hw/ex_stage.sv
  - target: test
    files:
      - verification/ex_stage_assertions.sv
      - verification/ex_stage_tb.sv
